/* sim/noc_vc_router_asserts.sv */
`timescale 1ns/10ps

`include "noc_macros.svh"

module noc_vc_router_asserts (
  input  logic                                           clk_i,
  input  logic                                           reset_i,
  input  logic [`NOC_NUM_PORTS-1:0]                      in_valid_i,
  input  noc_pkg::noc_flit_t [`NOC_NUM_PORTS-1:0]        in_flit_i,
  input  noc_pkg::noc_credit_t [`NOC_NUM_PORTS-1:0]      out_credit_i,
  input  logic [`NOC_NUM_PORTS-1:0]                      out_valid_i,
  input  logic [`NOC_NUM_PORTS-1:0][`NOC_NUM_PORTS-1:0]  sa_grant_i,
  input  logic [`NOC_NUM_PORTS-1:0][noc_pkg::VC_W-1:0]   grant_vc_i,
  input  logic [`NOC_NUM_PORTS-1:0][`NOC_NUM_VC-1:0]     count_nonzero_i
);
  import noc_pkg::*;

  // failed properties, read by the testbench at the end of the run
  int unsigned              fail_count;
  // flits accepted on each input vc and not yet credited back
  int                       pending [`NOC_NUM_PORTS][`NOC_NUM_VC];
  logic [`NOC_NUM_PORTS-1:0] credit_valid;

  always_comb begin
    for (int p = 0; p < `NOC_NUM_PORTS; p++) begin
      credit_valid[p] = out_credit_i[p].valid;
    end
  end

  always @(posedge clk_i) begin
    for (int p = 0; p < `NOC_NUM_PORTS; p++) begin
      for (int v = 0; v < `NOC_NUM_VC; v++) begin
        if (reset_i) begin
          pending[p][v] <= 0;
        end else begin
          pending[p][v] <= pending[p][v]
                           + int'(in_valid_i[p] && (in_flit_i[p].vc == VC_W'(v)))
                           - int'(out_credit_i[p].valid && (out_credit_i[p].vc == VC_W'(v)));
        end
      end
    end
  end

  // ============================================================
  // allocation and credit properties
  // ============================================================

  for (genvar o = 0; o < `NOC_NUM_PORTS; o++) begin : gen_port
    // at most one input wins each output
    a_grant_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
      $onehot0(sa_grant_i[o]))
      else begin
        $error("more than one input granted on output %0d", o);
        fail_count++;
      end

    // a grant needs a free slot in the downstream vc
    a_grant_credit: assert property (@(posedge clk_i) disable iff (reset_i)
      (|sa_grant_i[o]) |-> count_nonzero_i[o][grant_vc_i[o]])
      else begin
        $error("output %0d granted vc %0d with an empty credit counter", o, grant_vc_i[o]);
        fail_count++;
      end

    // o taken as the input index here
    a_credit_covered: assert property (@(posedge clk_i) disable iff (reset_i)
      out_credit_i[o].valid |-> (pending[o][out_credit_i[o].vc] > 0))
      else begin
        $error("input %0d returned a credit for a flit it never accepted", o);
        fail_count++;
      end
  end

  // registered outputs stay quiet through reset and the cycle after
  a_quiet_reset: assert property (@(posedge clk_i)
    reset_i |=> ((out_valid_i == '0) && (credit_valid == '0)))
    else begin
      $error("data_valid_o or credit_o active during reset");
      fail_count++;
    end

endmodule

bind noc_vc_router noc_vc_router_asserts noc_vc_router_asserts_i (
  .clk_i           (clk_i),
  .reset_i         (reset_i),
  .in_valid_i      (data_valid_i),
  .in_flit_i       (data_i),
  .out_credit_i    (credit_o),
  .out_valid_i     (data_valid_o),
  .sa_grant_i      (sa_grant),
  .grant_vc_i      (grant_vc),
  .count_nonzero_i (count_nonzero)
);

/* sim/noc_vc_router_tb.sv */
`timescale 1ns/10ps

`include "noc_macros.svh"

module noc_vc_router_tb;
  import noc_pkg::*;

  localparam int NP           = `NOC_NUM_PORTS;
  localparam int NV           = `NOC_NUM_VC;
  localparam int CLK_HALF_NS  = 5;
  localparam int RESET_CYCLES = 4;
  localparam int RAND_CYCLES  = 400;
  localparam int BP_CYCLES    = 60;
  localparam int CONT_CYCLES  = 80;
  localparam int DRAIN_LIMIT  = 200;
  localparam int PH_RANDOM    = 0;
  localparam int PH_BACKPRESS = 1;
  localparam int PH_CONTEND   = 2;
  // each phase cycle offers at most one flit per input, plus the lone flits
  localparam int MAX_FLITS    = NP * (RAND_CYCLES + BP_CYCLES + CONT_CYCLES) + 8;
  localparam int FLIT_CYCLES  = 4;
  localparam longint WATCHDOG_NS = longint'(MAX_FLITS) * FLIT_CYCLES * 2 * CLK_HALF_NS;
  localparam logic [31:0] SEED = 32'he3ba_4223;

  logic                  clk_i;
  logic                  reset_i;
  noc_coord_t            xy_id_i;
  logic [NP-1:0]         data_valid_i;
  noc_flit_t [NP-1:0]    data_i;
  noc_credit_t [NP-1:0]  credit_o;
  logic [NP-1:0]         data_valid_o;
  noc_flit_t [NP-1:0]    data_o;
  noc_credit_t [NP-1:0]  credit_i;

  // ============================================================
  // scoreboard and traffic models
  // ============================================================

  int        errors;
  int        sent;
  int        received;
  int        in_flight;
  int        cycle;
  int        up_credit [NP][NV];
  int        down_free [NP][NV];
  // indexed [input][vc][expected output]
  noc_flit_t sb [NP][NV][NP][$];
  // downstream credits waiting to go back, vc and due cycle
  int        pend_vc [NP][$];
  int        pend_due [NP][$];
  bit        hold [NP][NV];
  bit        bp_on;
  bit        contend_on;
  int        held_sent;
  int        other_sent;
  int        grant_no;
  int        last_grant [4];

  always #(CLK_HALF_NS) clk_i = ~clk_i;

  noc_vc_router noc_vc_router_i (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .xy_id_i      (xy_id_i),
    .data_valid_i (data_valid_i),
    .data_i       (data_i),
    .credit_o     (credit_o),
    .data_valid_o (data_valid_o),
    .data_o       (data_o),
    .credit_i     (credit_i)
  );

  task automatic report_mismatch(input string name, input longint got, input longint exp);
    errors++;
    $display("CHECK FAILED at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
  endtask

  task automatic report_problem(input string msg);
    errors++;
    $display("ERROR at %0t ns: %s", $time, msg);
  endtask

  function automatic noc_coord_t coord(input int x, input int y);
    noc_coord_t c;
    c.x = x[`NOC_COORD_W-1:0];
    c.y = y[`NOC_COORD_W-1:0];
    return c;
  endfunction

  // dimension order, x first, north is the larger y
  function automatic int expected_port(input noc_coord_t dst);
    if (dst.x > xy_id_i.x) return 1;
    if (dst.x < xy_id_i.x) return 3;
    if (dst.y > xy_id_i.y) return 0;
    if (dst.y < xy_id_i.y) return 2;
    return 4;
  endfunction

  // xy routing never turns a flit back through its own port
  function automatic noc_coord_t random_dst(input int p);
    noc_coord_t d;
    do begin
      d = coord($urandom_range(3, 0), $urandom_range(3, 0));
    end while (expected_port(d) == p);
    return d;
  endfunction

  // falling edge, clear the valids and collect returned credits
  task automatic next_cycle();
    @(negedge clk_i);
    data_valid_i = '0;
    for (int p = 0; p < NP; p++) begin
      if (credit_o[p].valid) begin
        up_credit[p][credit_o[p].vc]++;
        assert (up_credit[p][credit_o[p].vc] <= `NOC_VC_DEPTH)
          else report_problem($sformatf("input %0d returned more credits than flits", p));
      end
    end
  endtask

  task automatic send_flit(input int p, input noc_coord_t dst, input int vc);
    noc_flit_t f;
    f.dst     = dst;
    f.vc      = VC_W'(vc);
    // top bits carry the input index so the monitor finds the right queue
    f.payload = {3'(p), 13'($urandom)};
    data_valid_i[p] = 1'b1;
    data_i[p]       = f;
    up_credit[p][vc]--;
    sb[p][vc][expected_port(dst)].push_back(f);
    in_flight++;
    sent++;
  endtask

  // one flit through an idle router, exact one-cycle latency
  task automatic lone_flit(input int p, input int x, input int y, input int vc);
    int o;
    o = expected_port(coord(x, y));
    next_cycle();
    send_flit(p, coord(x, y), vc);
    next_cycle();
    assert (data_valid_o == '0) else report_mismatch("data_valid_o", data_valid_o, 0);
    next_cycle();
    assert (data_valid_o[o]) else report_mismatch($sformatf("data_valid_o[%0d]", o), 0, 1);
    assert (credit_o[p].valid && (credit_o[p].vc == VC_W'(vc)))
      else report_mismatch($sformatf("credit_o[%0d]", p), credit_o[p], {1'b1, VC_W'(vc)});
  endtask

  task automatic run_phase(input int kind, input int cycles);
    noc_coord_t dst;
    int vc;
    for (int c = 0; c < cycles; c++) begin
      next_cycle();
      for (int p = 0; p < NP; p++) begin
        vc = $urandom_range(NV - 1, 0);
        if (kind == PH_RANDOM) begin
          if ($urandom_range(1, 0) == 0) continue;
          dst = random_dst(p);
        end else if (kind == PH_BACKPRESS) begin
          // local feeds east, west feeds north
          if (p == 4) dst = coord(2, 1);
          else if (p == 3) dst = coord(1, 3);
          else continue;
        end else begin
          // four neighbours all aim at the local port on vc 0
          if (p == 4) continue;
          dst = coord(1, 1);
          vc  = 0;
        end
        if ((up_credit[p][vc] == 0) && (kind != PH_CONTEND)) vc = NV - 1 - vc;
        if (up_credit[p][vc] > 0) send_flit(p, dst, vc);
      end
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while ((in_flight > 0) && (waited < DRAIN_LIMIT)) begin
      next_cycle();
      waited++;
    end
    if (in_flight > 0) report_problem($sformatf("%0d flits never left the router", in_flight));
    // let the downstream credits settle
    repeat (8) next_cycle();
  endtask

  // ============================================================
  // output monitor and downstream credit model
  // ============================================================

  always @(negedge clk_i) begin : monitor
    noc_flit_t f;
    noc_flit_t exp_f;
    int src;
    int v;
    int k;
    cycle++;
    if (!reset_i) begin
      for (int o = 0; o < NP; o++) begin
        credit_i[o] = '0;
        if (data_valid_o[o]) begin
          f   = data_o[o];
          v   = f.vc;
          src = f.payload[15:13];
          assert (expected_port(f.dst) == o)
            else report_mismatch($sformatf("output of flit to %0d,%0d", f.dst.x, f.dst.y),
                                 o, expected_port(f.dst));
          if ((src < NP) && (sb[src][v][o].size() > 0)) begin
            exp_f = sb[src][v][o].pop_front();
            assert (f == exp_f) else report_mismatch($sformatf("data_o[%0d]", o), f, exp_f);
            in_flight--;
            received++;
          end else begin
            report_problem($sformatf("output %0d sent a flit that no input has pending", o));
          end
          down_free[o][v]--;
          assert (down_free[o][v] >= 0)
            else report_problem($sformatf("output %0d vc %0d sent without a credit", o, v));
          pend_vc[o].push_back(v);
          pend_due[o].push_back(cycle + $urandom_range(3, 0));
          if (bp_on && (o == 1) && (v == 0)) held_sent++;
          else if (bp_on) other_sent++;
          // fairness window over consecutive grants of the local output
          if (contend_on && (o == 4) && (src < 4)) begin
            grant_no++;
            last_grant[src] = grant_no;
            for (int i = 0; i < 4; i++) begin
              assert ((grant_no < 4) || (grant_no - last_grant[i] < 4))
                else report_problem($sformatf("input %0d missed four local grants", i));
            end
          end
        end
        // oldest due credit goes back unless its vc is held
        for (k = 0; k < pend_vc[o].size(); k++) begin
          if ((pend_due[o][k] <= cycle) && !hold[o][pend_vc[o][k]]) break;
        end
        if (k < pend_vc[o].size()) begin
          credit_i[o].valid = 1'b1;
          credit_i[o].vc    = VC_W'(pend_vc[o][k]);
          down_free[o][pend_vc[o][k]]++;
          pend_vc[o].delete(k);
          pend_due[o].delete(k);
        end
      end
    end
  end

  // ============================================================
  // test sequence
  // ============================================================

  initial begin
    void'($urandom(SEED));
    clk_i        = 1'b0;
    reset_i      = 1'b1;
    xy_id_i      = coord(1, 1);
    data_valid_i = '0;
    data_i       = '0;
    credit_i     = '0;
    for (int p = 0; p < NP; p++) begin
      for (int v = 0; v < NV; v++) begin
        up_credit[p][v] = `NOC_VC_DEPTH;
        down_free[p][v] = `NOC_VC_DEPTH;
      end
    end
    repeat (RESET_CYCLES) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;

    lone_flit(4, 3, 1, 1);
    lone_flit(0, 1, 0, 0);
    lone_flit(1, 0, 2, 1);
    lone_flit(3, 1, 1, 0);
    wait_drain();

    run_phase(PH_RANDOM, RAND_CYCLES);
    wait_drain();

    // east output vc 0 gets no credits back for a while
    hold[1][0] = 1'b1;
    bp_on      = 1'b1;
    run_phase(PH_BACKPRESS, BP_CYCLES);
    assert (held_sent <= `NOC_VC_DEPTH)
      else report_problem($sformatf("%0d flits left on a held output vc", held_sent));
    assert (other_sent > 0) else report_problem("no other traffic moved while a vc was held");
    hold[1][0] = 1'b0;
    bp_on      = 1'b0;
    wait_drain();

    contend_on = 1'b1;
    run_phase(PH_CONTEND, CONT_CYCLES);
    contend_on = 1'b0;
    wait_drain();
    assert (grant_no > 4) else report_problem("local output saw too few grants under contention");

    assert (received == sent) else report_mismatch("flits received", received, sent);
    $display("flits sent %0d received %0d, check errors %0d, assertion errors %0d",
             sent, received, errors, noc_vc_router_i.noc_vc_router_asserts_i.fail_count);
    if ((errors == 0) && (noc_vc_router_i.noc_vc_router_asserts_i.fail_count == 0)) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // bound derived from the largest possible flit count
  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns with %0d flits in the router",
             WATCHDOG_NS, in_flight);
    $display(">>> FAIL");
    $finish;
  end

endmodule

/* source/noc_credit_counter.sv */
`timescale 1ns/10ps

`include "noc_macros.svh"

module noc_credit_counter (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  noc_pkg::noc_credit_t         credit_i,
  input  logic                         consume_i,
  input  logic [noc_pkg::VC_W-1:0]     consume_vc_i,
  output logic [`NOC_NUM_VC-1:0]       count_nonzero_o
);
  import noc_pkg::*;

  localparam int CNT_W = $clog2(`NOC_VC_DEPTH + 1);

  // free slots in each downstream vc buffer
  logic [CNT_W-1:0]       count [`NOC_NUM_VC];
  logic [`NOC_NUM_VC-1:0] inc;
  logic [`NOC_NUM_VC-1:0] dec;

  always_comb begin
    for (int v = 0; v < `NOC_NUM_VC; v++) begin
      inc[v] = credit_i.valid && (credit_i.vc == VC_W'(v));
      dec[v] = consume_i && (consume_vc_i == VC_W'(v));
      count_nonzero_o[v] = (count[v] != '0);
    end
  end

  // returned credit and a send in one cycle cancel out
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int v = 0; v < `NOC_NUM_VC; v++) begin
        count[v] <= CNT_W'(`NOC_VC_DEPTH);
      end
    end else begin
      for (int v = 0; v < `NOC_NUM_VC; v++) begin
        if (inc[v] && !dec[v] && (count[v] != CNT_W'(`NOC_VC_DEPTH))) begin
          count[v] <= count[v] + 1'b1;
        end else if (dec[v] && !inc[v] && (count[v] != '0)) begin
          count[v] <= count[v] - 1'b1;
        end
      end
    end
  end

endmodule

/* source/noc_input_port.sv */
`timescale 1ns/10ps

`include "noc_macros.svh"

module noc_input_port (
  input  logic                                      clk_i,
  input  logic                                      reset_i,
  input  noc_pkg::noc_coord_t                       xy_id_i,
  input  logic                                      data_valid_i,
  input  noc_pkg::noc_flit_t                        data_i,
  input  logic                                      pop_i,
  input  logic [noc_pkg::VC_W-1:0]                  pop_vc_i,
  output logic [`NOC_NUM_VC-1:0]                    head_valid_o,
  output noc_pkg::route_dir_e [`NOC_NUM_VC-1:0]     head_dir_o,
  output noc_pkg::noc_flit_t [`NOC_NUM_VC-1:0]      head_flit_o,
  output noc_pkg::noc_credit_t                      credit_o
);
  import noc_pkg::*;

  localparam int PTR_W = (`NOC_VC_DEPTH > 1) ? $clog2(`NOC_VC_DEPTH) : 1;
  localparam int CNT_W = $clog2(`NOC_VC_DEPTH + 1);

  // one circular buffer per vc
  noc_flit_t              fifo_mem [`NOC_NUM_VC][`NOC_VC_DEPTH];
  logic [PTR_W-1:0]       wr_ptr   [`NOC_NUM_VC];
  logic [PTR_W-1:0]       rd_ptr   [`NOC_NUM_VC];
  logic [CNT_W-1:0]       fill     [`NOC_NUM_VC];
  logic [`NOC_NUM_VC-1:0] push;
  logic [`NOC_NUM_VC-1:0] pop;

  // wrap at the fifo depth, which need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(`NOC_VC_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // dimension-order route, x resolved before y
  function automatic route_dir_e xy_route(input noc_coord_t dst, input noc_coord_t here);
    route_dir_e dir;
    if (dst.x > here.x) begin
      dir = DIR_EAST;
    end else if (dst.x < here.x) begin
      dir = DIR_WEST;
    end else if (dst.y > here.y) begin
      dir = DIR_NORTH;
    end else if (dst.y < here.y) begin
      dir = DIR_SOUTH;
    end else begin
      dir = DIR_LOCAL;
    end
    return dir;
  endfunction

  // incoming flit goes to the fifo named by its vc field
  always_comb begin
    for (int v = 0; v < `NOC_NUM_VC; v++) begin
      push[v] = data_valid_i && (data_i.vc == VC_W'(v));
      pop[v]  = pop_i && (pop_vc_i == VC_W'(v));
    end
  end

  always_ff @(posedge clk_i) begin
    for (int v = 0; v < `NOC_NUM_VC; v++) begin
      if (push[v]) begin
        fifo_mem[v][wr_ptr[v]] <= data_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int v = 0; v < `NOC_NUM_VC; v++) begin
        wr_ptr[v] <= '0;
        rd_ptr[v] <= '0;
        fill[v]   <= '0;
      end
    end else begin
      for (int v = 0; v < `NOC_NUM_VC; v++) begin
        if (push[v]) begin
          wr_ptr[v] <= ptr_next(wr_ptr[v]);
        end
        if (pop[v]) begin
          rd_ptr[v] <= ptr_next(rd_ptr[v]);
        end
        // simultaneous push and pop keeps the fill level
        case ({push[v], pop[v]})
          2'b10:   fill[v] <= fill[v] + 1'b1;
          2'b01:   fill[v] <= fill[v] - 1'b1;
          default: fill[v] <= fill[v];
        endcase
      end
    end
  end

  // head flit and its route, valid the cycle after the write
  always_comb begin
    for (int v = 0; v < `NOC_NUM_VC; v++) begin
      head_valid_o[v] = (fill[v] != '0);
      head_flit_o[v]  = fifo_mem[v][rd_ptr[v]];
      head_dir_o[v]   = xy_route(fifo_mem[v][rd_ptr[v]].dst, xy_id_i);
    end
  end

  // credit back upstream, aligned with the switch traversal register
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      credit_o <= '0;
    end else begin
      credit_o.valid <= pop_i;
      credit_o.vc    <= pop_vc_i;
    end
  end

endmodule

/* source/noc_macros.svh */
`ifndef NOC_MACROS_SVH
`define NOC_MACROS_SVH

// physical ports in the order north, east, south, west, local
`define NOC_NUM_PORTS 5

// virtual channels carried by every physical port
`define NOC_NUM_VC 2

// flit slots per vc fifo
// also the value each output credit counter starts from
`define NOC_VC_DEPTH 2

// bits of one mesh coordinate, x and y alike
`define NOC_COORD_W 2

`endif

/* source/noc_pkg.sv */
package noc_pkg;

  `include "noc_macros.svh"

  // ============================================================
  // widths
  // ============================================================

  // one bit selects between the two vcs
  localparam int VC_W      = $clog2(`NOC_NUM_VC);
  localparam int PAYLOAD_W = 16;

  // ============================================================
  // types
  // ============================================================

  // output direction, encoded as the physical port index
  typedef enum logic [2:0] {
    DIR_NORTH = 3'd0,
    DIR_EAST  = 3'd1,
    DIR_SOUTH = 3'd2,
    DIR_WEST  = 3'd3,
    DIR_LOCAL = 3'd4
  } route_dir_e;

  typedef struct packed {
    logic [`NOC_COORD_W-1:0] x;
    logic [`NOC_COORD_W-1:0] y;
  } noc_coord_t;

  // single-flit packet, vc number kept across the hop
  typedef struct packed {
    noc_coord_t           dst;
    logic [VC_W-1:0]      vc;
    logic [PAYLOAD_W-1:0] payload;
  } noc_flit_t;

  // one pulse returns one slot of the named vc
  typedef struct packed {
    logic            valid;
    logic [VC_W-1:0] vc;
  } noc_credit_t;

  // local allocator choice, fanned out by dir at the top
  typedef struct packed {
    logic            valid;
    logic [VC_W-1:0] vc;
    route_dir_e      dir;
  } noc_req_t;

endpackage

/* source/noc_sa_global.sv */
`timescale 1ns/10ps

`include "noc_macros.svh"

module noc_sa_global (
  input  logic                                            clk_i,
  input  logic                                            reset_i,
  input  logic [`NOC_NUM_PORTS-1:0]                       req_valid_i,
  input  logic [`NOC_NUM_PORTS-1:0][noc_pkg::VC_W-1:0]    req_vc_i,
  output logic [`NOC_NUM_PORTS-1:0]                       grant_o,
  output logic [noc_pkg::VC_W-1:0]                        grant_vc_o
);
  import noc_pkg::*;

  localparam int PORT_W = $clog2(`NOC_NUM_PORTS);

  logic [PORT_W-1:0] rr_ptr;
  logic [PORT_W-1:0] win_idx;
  logic              win_valid;

  // first requesting input at or after the pointer
  always_comb begin
    logic [PORT_W-1:0] idx;
    win_valid = 1'b0;
    win_idx   = rr_ptr;
    for (int i = 0; i < `NOC_NUM_PORTS; i++) begin
      idx = PORT_W'((int'(rr_ptr) + i) % `NOC_NUM_PORTS);
      if (!win_valid && req_valid_i[idx]) begin
        win_valid = 1'b1;
        win_idx   = idx;
      end
    end
  end

  // one-hot grant back to the inputs
  always_comb begin
    grant_o = '0;
    grant_o[win_idx] = win_valid;
  end

  // vc of the winning request steers the crossbar and the counter
  assign grant_vc_o = req_vc_i[win_idx];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rr_ptr <= '0;
    end else if (win_valid) begin
      if (win_idx == PORT_W'(`NOC_NUM_PORTS - 1)) begin
        rr_ptr <= '0;
      end else begin
        rr_ptr <= win_idx + 1'b1;
      end
    end
  end

endmodule

/* source/noc_sa_local.sv */
`timescale 1ns/10ps

`include "noc_macros.svh"

module noc_sa_local (
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  input  logic [`NOC_NUM_VC-1:0]                head_valid_i,
  input  noc_pkg::route_dir_e [`NOC_NUM_VC-1:0] head_dir_i,
  input  logic [`NOC_NUM_VC-1:0]                credit_avail_i,
  input  logic                                  grant_i,
  output noc_pkg::noc_req_t                     req_o
);
  import noc_pkg::*;

  logic [`NOC_NUM_VC-1:0] eligible;
  logic [VC_W-1:0]        rr_ptr;
  logic [VC_W-1:0]        pick_vc;
  logic                   pick_valid;

  // a vc competes only with a head and a free downstream slot
  assign eligible = head_valid_i & credit_avail_i;

  // scan from the round-robin pointer, first eligible vc wins
  always_comb begin
    logic [VC_W-1:0] idx;
    pick_valid = 1'b0;
    pick_vc    = rr_ptr;
    for (int i = 0; i < `NOC_NUM_VC; i++) begin
      idx = VC_W'((int'(rr_ptr) + i) % `NOC_NUM_VC);
      if (!pick_valid && eligible[idx]) begin
        pick_valid = 1'b1;
        pick_vc    = idx;
      end
    end
  end

  assign req_o.valid = pick_valid;
  assign req_o.vc    = pick_vc;
  assign req_o.dir   = head_dir_i[pick_vc];

  // pointer holds on a lost request so the same vc asks again
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rr_ptr <= '0;
    end else if (grant_i) begin
      if (pick_vc == VC_W'(`NOC_NUM_VC - 1)) begin
        rr_ptr <= '0;
      end else begin
        rr_ptr <= pick_vc + 1'b1;
      end
    end
  end

endmodule

/* source/noc_switch_traversal.sv */
`timescale 1ns/10ps

`include "noc_macros.svh"

module noc_switch_traversal (
  input  logic                                                  clk_i,
  input  logic                                                  reset_i,
  // per output, one-hot over inputs
  input  logic [`NOC_NUM_PORTS-1:0][`NOC_NUM_PORTS-1:0]         grant_i,
  // head of every vc of every input
  input  noc_pkg::noc_flit_t [`NOC_NUM_PORTS-1:0][`NOC_NUM_VC-1:0] head_flit_i,
  input  logic [`NOC_NUM_PORTS-1:0][noc_pkg::VC_W-1:0]          grant_vc_i,
  output logic [`NOC_NUM_PORTS-1:0]                             data_valid_o,
  output noc_pkg::noc_flit_t [`NOC_NUM_PORTS-1:0]               data_o
);
  import noc_pkg::*;

  noc_flit_t [`NOC_NUM_PORTS-1:0] xbar_flit;
  logic [`NOC_NUM_PORTS-1:0]      out_busy;

  // crossbar select, granted input and its granted vc
  always_comb begin
    for (int o = 0; o < `NOC_NUM_PORTS; o++) begin
      xbar_flit[o] = '0;
      out_busy[o]  = |grant_i[o];
      for (int i = 0; i < `NOC_NUM_PORTS; i++) begin
        if (grant_i[o][i]) begin
          xbar_flit[o] = head_flit_i[i][grant_vc_i[o]];
        end
      end
    end
  end

  // ============================================================
  // traversal register
  // ============================================================

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      data_valid_o <= '0;
    end else begin
      data_valid_o <= out_busy;
    end
  end

  // link data only loads on a grant
  always_ff @(posedge clk_i) begin
    for (int o = 0; o < `NOC_NUM_PORTS; o++) begin
      if (out_busy[o]) begin
        data_o[o] <= xbar_flit[o];
      end
    end
  end

endmodule

/* source/noc_vc_router.sv */
`timescale 1ns/10ps

`include "noc_macros.svh"

module noc_vc_router (
  input  logic                                      clk_i,
  input  logic                                      reset_i,
  input  noc_pkg::noc_coord_t                       xy_id_i,
  // upstream side of each port
  input  logic [`NOC_NUM_PORTS-1:0]                 data_valid_i,
  input  noc_pkg::noc_flit_t [`NOC_NUM_PORTS-1:0]   data_i,
  output noc_pkg::noc_credit_t [`NOC_NUM_PORTS-1:0] credit_o,
  // downstream side of each port
  output logic [`NOC_NUM_PORTS-1:0]                 data_valid_o,
  output noc_pkg::noc_flit_t [`NOC_NUM_PORTS-1:0]   data_o,
  input  noc_pkg::noc_credit_t [`NOC_NUM_PORTS-1:0] credit_i
);
  import noc_pkg::*;

  // ============================================================
  // wiring
  // ============================================================

  logic [`NOC_NUM_PORTS-1:0][`NOC_NUM_VC-1:0]       head_valid;
  route_dir_e [`NOC_NUM_PORTS-1:0][`NOC_NUM_VC-1:0] head_dir;
  noc_flit_t [`NOC_NUM_PORTS-1:0][`NOC_NUM_VC-1:0]  head_flit;
  logic [`NOC_NUM_PORTS-1:0][`NOC_NUM_VC-1:0]       credit_avail;
  noc_req_t [`NOC_NUM_PORTS-1:0]                    sa_req;
  logic [`NOC_NUM_PORTS-1:0][VC_W-1:0]              req_vc;
  logic [`NOC_NUM_PORTS-1:0]                        in_grant;
  // indexed [output][input]
  logic [`NOC_NUM_PORTS-1:0][`NOC_NUM_PORTS-1:0]    req_valid_per_out;
  logic [`NOC_NUM_PORTS-1:0][`NOC_NUM_PORTS-1:0]    sa_grant;
  logic [`NOC_NUM_PORTS-1:0][VC_W-1:0]              grant_vc;
  logic [`NOC_NUM_PORTS-1:0]                        out_consume;
  // indexed [output][vc]
  logic [`NOC_NUM_PORTS-1:0][`NOC_NUM_VC-1:0]       count_nonzero;

  always_comb begin
    for (int p = 0; p < `NOC_NUM_PORTS; p++) begin
      // each head vc checks the same vc on the output it routes to
      for (int v = 0; v < `NOC_NUM_VC; v++) begin
        credit_avail[p][v] = count_nonzero[head_dir[p][v]][v];
      end
      req_vc[p]   = sa_req[p].vc;
      in_grant[p] = sa_req[p].valid && sa_grant[sa_req[p].dir][p];
    end
    // fan the local requests out by direction
    for (int o = 0; o < `NOC_NUM_PORTS; o++) begin
      out_consume[o] = |sa_grant[o];
      for (int p = 0; p < `NOC_NUM_PORTS; p++) begin
        req_valid_per_out[o][p] = sa_req[p].valid && (sa_req[p].dir == route_dir_e'(o));
      end
    end
  end

  // ============================================================
  // per-port blocks
  // ============================================================

  for (genvar p = 0; p < `NOC_NUM_PORTS; p++) begin : gen_port
    noc_input_port i_input_port (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .xy_id_i      (xy_id_i),
      .data_valid_i (data_valid_i[p]),
      .data_i       (data_i[p]),
      .pop_i        (in_grant[p]),
      .pop_vc_i     (sa_req[p].vc),
      .head_valid_o (head_valid[p]),
      .head_dir_o   (head_dir[p]),
      .head_flit_o  (head_flit[p]),
      .credit_o     (credit_o[p])
    );

    noc_sa_local i_sa_local (
      .clk_i          (clk_i),
      .reset_i        (reset_i),
      .head_valid_i   (head_valid[p]),
      .head_dir_i     (head_dir[p]),
      .credit_avail_i (credit_avail[p]),
      .grant_i        (in_grant[p]),
      .req_o          (sa_req[p])
    );

    // output side, p taken as the output index
    noc_sa_global i_sa_global (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .req_valid_i (req_valid_per_out[p]),
      .req_vc_i    (req_vc),
      .grant_o     (sa_grant[p]),
      .grant_vc_o  (grant_vc[p])
    );

    noc_credit_counter i_credit_counter (
      .clk_i           (clk_i),
      .reset_i         (reset_i),
      .credit_i        (credit_i[p]),
      .consume_i       (out_consume[p]),
      .consume_vc_i    (grant_vc[p]),
      .count_nonzero_o (count_nonzero[p])
    );
  end

  noc_switch_traversal i_switch_traversal (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .grant_i      (sa_grant),
    .head_flit_i  (head_flit),
    .grant_vc_i   (grant_vc),
    .data_valid_o (data_valid_o),
    .data_o       (data_o)
  );

endmodule

/* vlog.f */
+incdir+source
source/noc_pkg.sv
source/noc_input_port.sv
source/noc_sa_local.sv
source/noc_sa_global.sv
source/noc_credit_counter.sv
source/noc_switch_traversal.sv
source/noc_vc_router.sv
sim/noc_vc_router_asserts.sv
sim/noc_vc_router_tb.sv
